// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = cpuCoreTb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/alu.sv
// arithmetic and logic unit, zero flag on operand a
`default_nettype none

module alu
  import cpuPkg::*;
(
  input  aluOpT aluOp,
  input  wordT  a,
  input  wordT  b,
  output wordT  result,
  output logic  zero
);

  always_comb begin
    case (aluOp)
      ALU_ADD:   result = a + b;
      ALU_SUB:   result = a - b;
      ALU_AND:   result = a & b;
      ALU_OR:    result = a | b;
      ALU_XOR:   result = a ^ b;
      ALU_PASSB: result = b;
      default:   result = '0;
    endcase
  end

  // BEQZ tests the register on port A
  assign zero = (a == '0);

endmodule

`default_nettype wire

// File: design/controlFsm.sv
// sequencer for fetch, decode, execute and data access
// runs the four-phase memory handshake and pulses the datapath enables
`default_nettype none

module controlFsm (
  input  wire  clk,
  input  wire  reset,
  input  wire  memAck,
  input  wire  memAccess,
  input  wire  memWrite,
  input  wire  isBranch,
  input  wire  isHalt,
  input  wire  regWrite,
  input  wire  aluZero,
  output logic memReq,
  output logic memWe,
  output logic addrSelData,
  output logic irLoad,
  output logic mdrLoad,
  output logic pcIncr,
  output logic pcLoad,
  output logic regWe,
  output logic halted
);

  typedef enum logic [2:0] {
    fetchReq,
    fetchRelease,
    decode,
    execute,
    dataReq,
    dataRelease,
    writeBack,
    halt
  } stateT;

  stateT state;
  logic  branchTaken;

  assign branchTaken = isBranch && aluZero;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= fetchReq;
      memReq      <= 1'b0;
      memWe       <= 1'b0;
      addrSelData <= 1'b0;
      irLoad      <= 1'b0;
      mdrLoad     <= 1'b0;
      pcIncr      <= 1'b0;
      pcLoad      <= 1'b0;
      regWe       <= 1'b0;
      halted      <= 1'b0;
    end else begin
      // enables are single-cycle pulses
      irLoad  <= 1'b0;
      mdrLoad <= 1'b0;
      pcIncr  <= 1'b0;
      pcLoad  <= 1'b0;
      regWe   <= 1'b0;
      case (state)
        fetchReq: begin
          if (!memReq && !memAck) begin
            memReq <= 1'b1;
          end else if (memReq && memAck) begin
            // rdata still valid next cycle, ack cannot drop before req does
            memReq <= 1'b0;
            irLoad <= 1'b1;
            state  <= fetchRelease;
          end
        end
        fetchRelease: begin
          if (!memAck) begin
            state <= decode;
          end
        end
        decode: begin
          // register operands settled, so the zero flag is final here
          regWe  <= regWrite && !memAccess;
          pcLoad <= branchTaken;
          pcIncr <= !branchTaken && !isHalt;
          if (isHalt) begin
            halted <= 1'b1;
          end
          state <= execute;
        end
        execute: begin
          if (isHalt) begin
            state <= halt;
          end else if (memAccess) begin
            memReq      <= !memAck;
            memWe       <= memWrite;
            addrSelData <= 1'b1;
            state       <= dataReq;
          end else begin
            memReq <= !memAck;
            state  <= fetchReq;
          end
        end
        dataReq: begin
          if (!memReq && !memAck) begin
            memReq <= 1'b1;
          end else if (memReq && memAck) begin
            memReq  <= 1'b0;
            mdrLoad <= !memWrite;
            state   <= dataRelease;
          end
        end
        dataRelease: begin
          if (!memAck) begin
            memWe       <= 1'b0;
            addrSelData <= 1'b0;
            regWe       <= regWrite;
            state       <= writeBack;
          end
        end
        writeBack: begin
          memReq <= !memAck;
          state  <= fetchReq;
        end
        halt: begin
          state <= halt;
        end
      endcase
    end
  end

  // four-phase rule, a new request only after ack was seen low
  reqAfterAckLow: assert property (
    @(posedge clk) disable iff (reset) $rose(memReq) |-> !$past(memAck)
  );

  // halt is sticky until reset
  haltSticky: assert property (
    @(posedge clk) $fell(halted) |-> $past(reset)
  );

endmodule

`default_nettype wire

// File: design/cpuCore.sv
// core top level, datapath muxes, memory data register
// and the four-phase memory bus
`default_nettype none

module cpuCore
  import cpuPkg::*;
(
  input  wire  clk,
  input  wire  reset,
  input  wire  memAck,
  input  wordT memRdata,
  output logic memReq,
  output logic memWe,
  output wordT memAddr,
  output wordT memWdata,
  output logic halted
);

  logic   irLoad, mdrLoad, pcIncr, pcLoad, regWe, addrSelData;
  logic   regWrite, aluBSel, memAccess, memWrite, isBranch, isHalt;
  wbSelT  wbSel;
  aluOpT  aluOp;
  immSelT immSel;
  opcodeT opcode;
  regIdxT rdIdx, raIdx, rbIdx;
  logic   storeSelRd;
  wordT   imm, pc, rdataA, rdataB, aluB, aluResult, mdr, wbData;
  logic   aluZero;

  controlFsm controlFsm_inst (
    .clk(clk), .reset(reset), .memAck(memAck),
    .memAccess(memAccess), .memWrite(memWrite), .isBranch(isBranch),
    .isHalt(isHalt), .regWrite(regWrite), .aluZero(aluZero),
    .memReq(memReq), .memWe(memWe), .addrSelData(addrSelData),
    .irLoad(irLoad), .mdrLoad(mdrLoad), .pcIncr(pcIncr),
    .pcLoad(pcLoad), .regWe(regWe), .halted(halted)
  );

  microcodeRom microcodeRom_inst (
    .opcode(opcode), .regWrite(regWrite), .wbSel(wbSel), .aluOp(aluOp),
    .aluBSel(aluBSel), .immSel(immSel), .memAccess(memAccess),
    .memWrite(memWrite), .isBranch(isBranch), .isHalt(isHalt)
  );

  instrDecoder instrDecoder_inst (
    .clk(clk), .reset(reset), .irLoad(irLoad), .memRdata(memRdata),
    .immSel(immSel), .opcode(opcode), .rdIdx(rdIdx), .raIdx(raIdx),
    .rbIdx(rbIdx), .storeSelRd(storeSelRd), .imm(imm)
  );

  programCounter programCounter_inst (
    .clk(clk), .reset(reset), .pcIncr(pcIncr), .pcLoad(pcLoad),
    .branchOffset(imm), .pc(pc)
  );

  registerFile registerFile_inst (
    .clk(clk), .reset(reset), .we(regWe), .waddr(rdIdx), .wdata(wbData),
    .raddrA(raIdx), .raddrB(rbIdx), .rdataA(rdataA), .rdataB(rdataB)
  );

  alu alu_inst (
    .aluOp(aluOp), .a(rdataA), .b(aluB), .result(aluResult), .zero(aluZero)
  );

  assign aluB = aluBSel ? imm : rdataB;

  // memory data register, captured while ack is high
  always_ff @(posedge clk) begin
    if (mdrLoad) begin
      mdr <= memRdata;
    end
  end

  always_comb begin
    case (wbSel)
      WB_IMM:  wbData = imm;
      WB_MEM:  wbData = mdr;
      default: wbData = aluResult;
    endcase
  end

  // fetches use the PC, loads and stores the ALU sum
  assign memAddr  = addrSelData ? aluResult : pc;
  assign memWdata = storeSelRd ? rdataB : '0;

endmodule

`default_nettype wire

// File: design/cpuPkg.sv
// shared types, opcode, ALU and write-back encodings
// and the start address for the 16-bit microcoded core
`default_nettype none

package cpuPkg;

  // data, address and instruction word
  typedef logic [15:0] wordT;
  typedef logic [2:0]  regIdxT;
  typedef logic [3:0]  opcodeT;
  typedef logic [2:0]  aluOpT;
  typedef logic [1:0]  wbSelT;
  typedef logic        immSelT;

  // opcode slots, the rest are no-operations
  localparam opcodeT OP_ADD  = 4'd0;
  localparam opcodeT OP_SUB  = 4'd1;
  localparam opcodeT OP_AND  = 4'd2;
  localparam opcodeT OP_OR   = 4'd3;
  localparam opcodeT OP_XOR  = 4'd4;
  localparam opcodeT OP_ADDI = 4'd5;
  localparam opcodeT OP_LDI  = 4'd6;
  localparam opcodeT OP_LD   = 4'd7;
  localparam opcodeT OP_ST   = 4'd8;
  localparam opcodeT OP_BEQZ = 4'd9;
  localparam opcodeT OP_HALT = 4'd15;

  localparam aluOpT ALU_ADD   = 3'd0;
  localparam aluOpT ALU_SUB   = 3'd1;
  localparam aluOpT ALU_AND   = 3'd2;
  localparam aluOpT ALU_OR    = 3'd3;
  localparam aluOpT ALU_XOR   = 3'd4;
  localparam aluOpT ALU_PASSB = 3'd5;

  // write-back source
  localparam wbSelT WB_ALU = 2'd0;
  localparam wbSelT WB_IMM = 2'd1;
  localparam wbSelT WB_MEM = 2'd2;

  // immediate formats, both signed
  localparam immSelT IMM6 = 1'b0;
  localparam immSelT IMM9 = 1'b1;

  localparam wordT RESET_PC = 16'h0000;

endpackage

`default_nettype wire

// File: design/instrDecoder.sv
// instruction register, field split, read-port steering
// and sign extension of the 6- and 9-bit immediates
`default_nettype none

module instrDecoder
  import cpuPkg::*;
(
  input  wire    clk,
  input  wire    reset,
  input  wire    irLoad,
  input  wordT   memRdata,
  input  immSelT immSel,
  output opcodeT opcode,
  output regIdxT rdIdx,
  output regIdxT raIdx,
  output regIdxT rbIdx,
  output logic   storeSelRd,
  output wordT   imm
);

  wordT ir;

  always_ff @(posedge clk) begin
    if (reset) begin
      ir <= '0;
    end else if (irLoad) begin
      ir <= memRdata;
    end
  end

  assign opcode = ir[15:12];
  assign rdIdx  = ir[11:9];

  // store data comes from rd
  assign storeSelRd = (opcode == OP_ST);

  // BEQZ tests rd on port A, ST reads rd on port B while ra forms the address
  assign raIdx = (opcode == OP_BEQZ) ? rdIdx : ir[8:6];
  assign rbIdx = storeSelRd ? rdIdx : ir[5:3];

  always_comb begin
    if (immSel == IMM9) begin
      imm = {{7{ir[8]}}, ir[8:0]};
    end else begin
      imm = {{10{ir[5]}}, ir[5:0]};
    end
  end

endmodule

`default_nettype wire

// File: design/microcodeRom.sv
// microcode table, one control word per opcode
`default_nettype none

module microcodeRom
  import cpuPkg::*;
(
  input  opcodeT opcode,
  output logic   regWrite,
  output wbSelT  wbSel,
  output aluOpT  aluOp,
  output logic   aluBSel,
  output immSelT immSel,
  output logic   memAccess,
  output logic   memWrite,
  output logic   isBranch,
  output logic   isHalt
);

  // regWrite, wbSel, aluOp, aluBSel, immSel, then access/write/branch/halt
  logic [11:0] ctrlWord;

  always_comb begin
    case (opcode)
      OP_ADD:  ctrlWord = {1'b1, WB_ALU, ALU_ADD,   1'b0, IMM6, 4'b0000};
      OP_SUB:  ctrlWord = {1'b1, WB_ALU, ALU_SUB,   1'b0, IMM6, 4'b0000};
      OP_AND:  ctrlWord = {1'b1, WB_ALU, ALU_AND,   1'b0, IMM6, 4'b0000};
      OP_OR:   ctrlWord = {1'b1, WB_ALU, ALU_OR,    1'b0, IMM6, 4'b0000};
      OP_XOR:  ctrlWord = {1'b1, WB_ALU, ALU_XOR,   1'b0, IMM6, 4'b0000};
      OP_ADDI: ctrlWord = {1'b1, WB_ALU, ALU_ADD,   1'b1, IMM6, 4'b0000};
      OP_LDI:  ctrlWord = {1'b1, WB_IMM, ALU_PASSB, 1'b1, IMM9, 4'b0000};
      // address is ra plus imm6 for both memory ops
      OP_LD:   ctrlWord = {1'b1, WB_MEM, ALU_ADD,   1'b1, IMM6, 4'b1000};
      OP_ST:   ctrlWord = {1'b0, WB_ALU, ALU_ADD,   1'b1, IMM6, 4'b1100};
      OP_BEQZ: ctrlWord = {1'b0, WB_ALU, ALU_PASSB, 1'b1, IMM6, 4'b0010};
      OP_HALT: ctrlWord = {1'b0, WB_ALU, ALU_PASSB, 1'b0, IMM6, 4'b0001};
      // unused slots do nothing
      default: ctrlWord = {1'b0, WB_ALU, ALU_PASSB, 1'b0, IMM6, 4'b0000};
    endcase
  end

  assign {regWrite, wbSel, aluOp, aluBSel, immSel,
          memAccess, memWrite, isBranch, isHalt} = ctrlWord;

endmodule

`default_nettype wire

// File: design/programCounter.sv
// program counter with increment and relative branch load
`default_nettype none

module programCounter
  import cpuPkg::*;
(
  input  wire  clk,
  input  wire  reset,
  input  wire  pcIncr,
  input  wire  pcLoad,
  input  wordT branchOffset,
  output wordT pc
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (pcLoad) begin
      // target relative to the next instruction
      pc <= pc + 16'd1 + branchOffset;
    end else if (pcIncr) begin
      pc <= pc + 16'd1;
    end
  end

  oneUpdate: assert property (
    @(posedge clk) disable iff (reset) !(pcIncr && pcLoad)
  );

endmodule

`default_nettype wire

// File: design/registerFile.sv
// eight general registers, two combinational reads, one write
`default_nettype none

module registerFile
  import cpuPkg::*;
(
  input  wire    clk,
  input  wire    reset,
  input  wire    we,
  input  regIdxT waddr,
  input  wordT   wdata,
  input  regIdxT raddrA,
  input  regIdxT raddrB,
  output wordT   rdataA,
  output wordT   rdataB
);

  wordT regs [2**$bits(regIdxT)];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdataA = regs[raddrA];
  assign rdataB = regs[raddrB];

endmodule

`default_nettype wire

// File: dv/cpuChecker.sv
// instruction-set model of the core and a monitor on its memory bus
// compares bus transactions and the halt with the model
`default_nettype none

module cpuChecker
  import cpuPkg::*;
(
  input  wire  clk,
  input  wire  reset,
  input  wire  memReq,
  input  wire  memWe,
  input  wordT memAddr,
  input  wordT memWdata,
  input  wire  memAck,
  input  wire  halted,
  input  wordT progImage [256],
  output int   mismatchCount,
  output int   protocolCount,
  output int   haltCount
);

  timeunit 1ns;
  timeprecision 100ps;

  // expected bus transactions in program order
  wordT expAddr [$];
  logic expWe [$];
  wordT expData [$];
  int   mismatches = 0;
  int   protocolErrors = 0;
  int   halts = 0;
  int   modelStores, dutStores;
  logic modelHalted = 1'b0;
  logic prevReset = 1'b0;
  logic prevReq = 1'b0;
  logic prevAck = 1'b0;
  logic prevHalted = 1'b0;
  logic firstReq = 1'b1;
  logic txWe;
  wordT txAddr, txData;

  assign mismatchCount = mismatches;
  assign protocolCount = protocolErrors;
  assign haltCount     = halts;

  task automatic reportMismatch(string msg);
    mismatches++;
    $display("mismatch at %0d ns: %s", $time, msg);
  endtask

  task automatic reportProtocol(string msg);
    protocolErrors++;
    $display("bus protocol error at %0d ns: %s", $time, msg);
  endtask

  task automatic addExpected(wordT addr, logic we, wordT data);
    expAddr.push_back(addr);
    expWe.push_back(we);
    expData.push_back(data);
  endtask

  // runs the whole program and records every transaction
  task automatic runModel();
    wordT   image [256];
    wordT   regs [8];
    wordT   pc, ins, imm6, addr;
    regIdxT rd, ra, rb;
    int     steps;
    image = progImage;
    regs = '{default: '0};
    expAddr.delete();
    expWe.delete();
    expData.delete();
    pc = RESET_PC;
    steps = 0;
    modelStores = 0;
    dutStores = 0;
    modelHalted = 1'b0;
    while (!modelHalted && steps < 1000) begin
      addExpected(pc, 1'b0, '0);
      ins  = image[pc[7:0]];
      rd   = ins[11:9];
      ra   = ins[8:6];
      rb   = ins[5:3];
      imm6 = {{10{ins[5]}}, ins[5:0]};
      addr = regs[ra] + imm6;
      pc   = pc + 16'd1;
      case (ins[15:12])
        OP_ADD:  regs[rd] = regs[ra] + regs[rb];
        OP_SUB:  regs[rd] = regs[ra] - regs[rb];
        OP_AND:  regs[rd] = regs[ra] & regs[rb];
        OP_OR:   regs[rd] = regs[ra] | regs[rb];
        OP_XOR:  regs[rd] = regs[ra] ^ regs[rb];
        OP_ADDI: regs[rd] = regs[ra] + imm6;
        OP_LDI:  regs[rd] = {{7{ins[8]}}, ins[8:0]};
        OP_LD: begin
          addExpected(addr, 1'b0, '0);
          regs[rd] = image[addr[7:0]];
        end
        OP_ST: begin
          addExpected(addr, 1'b1, regs[rd]);
          image[addr[7:0]] = regs[rd];
          modelStores++;
        end
        // pc already points past the branch
        OP_BEQZ: begin
          if (regs[rd] == '0) begin
            pc = pc + imm6;
          end
        end
        OP_HALT: modelHalted = 1'b1;
        default: ;
      endcase
      steps++;
    end
  endtask

  task automatic startTransaction();
    wordT eAddr, eData;
    logic eWe;
    txAddr = memAddr;
    txWe   = memWe;
    txData = memWdata;
    // ack as the core saw it at the edge where memReq rose
    if (prevAck) begin
      reportProtocol("memReq rose while memAck was still high");
    end
    if (firstReq && memAddr != RESET_PC) begin
      reportMismatch($sformatf("first fetch after reset from %h, expected %h",
                               memAddr, RESET_PC));
    end
    firstReq = 1'b0;
    if (memWe) begin
      dutStores++;
    end
    if (expAddr.size() == 0) begin
      reportProtocol("memory request after the program reached HALT");
    end else begin
      eAddr = expAddr.pop_front();
      eWe   = expWe.pop_front();
      eData = expData.pop_front();
      if (memWe != eWe) begin
        reportMismatch($sformatf("memWe %0b at %h, expected memWe %0b at %h",
                                 memWe, memAddr, eWe, eAddr));
      end else if (memWe && (memAddr[7:0] != eAddr[7:0] || memWdata != eData)) begin
        reportMismatch($sformatf("store of %h to %h, expected %h to %h",
                                 memWdata, memAddr[7:0], eData, eAddr[7:0]));
      end else if (!memWe && memAddr != eAddr) begin
        reportMismatch($sformatf("read from %h, expected %h", memAddr, eAddr));
      end
    end
  endtask

  task automatic checkHalt();
    halts++;
    if (expAddr.size() != 0) begin
      reportMismatch($sformatf("halted with %0d transactions still expected",
                               expAddr.size()));
    end
    if (dutStores != modelStores) begin
      reportMismatch($sformatf("%0d stores before halt, expected %0d",
                               dutStores, modelStores));
    end
  endtask

  // sampled mid-cycle, away from the edges where the bus changes
  always @(negedge clk) begin
    if (reset) begin
      if (prevReset && (memReq || halted)) begin
        reportProtocol("memReq or halted is high while reset is applied");
      end
      firstReq = 1'b1;
    end else begin
      if (prevReset) begin
        runModel();
      end
      if (memReq && !prevReq) begin
        startTransaction();
      end else if (memReq && (memAddr != txAddr || memWe != txWe || memWdata != txData)) begin
        reportProtocol("memAddr, memWe or memWdata changed while memReq was high");
      end
      if (halted && !prevHalted) begin
        checkHalt();
      end
    end
    prevReset  = reset;
    prevReq    = memReq;
    prevAck    = memAck;
    prevHalted = halted;
  end

endmodule

`default_nettype wire

// File: dv/cpuCoreTb.sv
// testbench top with clock, reset, random programs,
// a memory responder with random latency and a watchdog
`default_nettype none

module cpuCoreTb
  import cpuPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PROGS   = 20;
  localparam int BODY_LEN    = 40;
  localparam int MEM_WORDS   = 256;
  // programs x instructions x cycles per instruction x period
  localparam int WATCHDOG_NS = NUM_PROGS * 45 * 20 * 10;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic memAck = 1'b0;
  wordT memRdata = '0;
  logic memReq, memWe, halted;
  wordT memAddr, memWdata;

  wordT progImage [MEM_WORDS];
  wordT mem [MEM_WORDS];
  int   seed = 22204;
  int   ackDelay = -1;
  int   mismatchCount, protocolCount, haltCount;
  logic seenReset, seenReq, seenWe;
  wordT seenAddr, seenWdata;

  cpuCore cpuCore_inst (
    .clk(clk), .reset(reset), .memAck(memAck), .memRdata(memRdata),
    .memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
    .halted(halted)
  );

  cpuChecker cpuChecker_inst (
    .clk(clk), .reset(reset), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
    .memWdata(memWdata), .memAck(memAck), .halted(halted), .progImage(progImage),
    .mismatchCount(mismatchCount), .protocolCount(protocolCount),
    .haltCount(haltCount)
  );

  always #5 clk = ~clk;

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic buildProgram();
    regIdxT rd, ra, rb;
    int     off;
    for (int a = 0; a < MEM_WORDS; a++) begin
      progImage[a] = {8'(a) ^ 8'h5a, 8'(a)};
    end
    // seed every register, r7 stays the data base in 160..223
    for (int r = 0; r < 7; r++) begin
      progImage[r] = {OP_LDI, regIdxT'(r), 9'(randBelow(512))};
    end
    progImage[7] = {OP_LDI, 3'd7, 9'(160 + randBelow(64))};
    for (int i = 8; i < BODY_LEN; i++) begin
      rd = regIdxT'(randBelow(7));
      ra = regIdxT'(randBelow(8));
      rb = regIdxT'(randBelow(8));
      case (randBelow(10))
        0: progImage[i] = {OP_ADD, rd, ra, rb, 3'b000};
        1: progImage[i] = {OP_SUB, rd, ra, rb, 3'b000};
        2: progImage[i] = {OP_AND, rd, ra, rb, 3'b000};
        3: progImage[i] = {OP_OR, rd, ra, rb, 3'b000};
        4: progImage[i] = {OP_XOR, rd, ra, rb, 3'b000};
        5: progImage[i] = {OP_ADDI, rd, ra, 6'(randBelow(64))};
        // small values so BEQZ finds zeros now and then
        6: progImage[i] = {OP_LDI, rd, 9'(randBelow(4))};
        7: progImage[i] = {OP_LD, rd, 3'd7, 6'(randBelow(64))};
        8: progImage[i] = {OP_ST, rb, 3'd7, 6'(randBelow(64))};
        default: begin
          off = randBelow(4);
          // never jump past the HALT
          if (i + 1 + off > BODY_LEN) begin
            off = BODY_LEN - i - 1;
          end
          progImage[i] = {OP_BEQZ, rb, 3'b000, 6'(off)};
        end
      endcase
    end
    progImage[BODY_LEN] = {OP_HALT, 12'h000};
    mem = progImage;
  endtask

  // bus sampled at the edge, answered 1 ns later
  always @(posedge clk) begin
    seenReset = reset;
    seenReq   = memReq;
    seenWe    = memWe;
    seenAddr  = memAddr;
    seenWdata = memWdata;
    #1;
    if (seenReset) begin
      memAck   = 1'b0;
      ackDelay = -1;
    end else if (memAck != seenReq) begin
      if (ackDelay < 0) begin
        ackDelay = randBelow(4);
      end
      if (ackDelay == 0) begin
        if (!memAck && seenWe) begin
          mem[seenAddr[7:0]] = seenWdata;
        end else if (!memAck) begin
          memRdata = mem[seenAddr[7:0]];
        end
        memAck   = !memAck;
        ackDelay = -1;
      end else begin
        ackDelay--;
      end
    end
  end

  initial begin
    seed = 22204;
    for (int p = 0; p < NUM_PROGS; p++) begin
      buildProgram();
      @(posedge clk);
      #1 reset = 1'b1;
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      while (!halted) begin
        @(posedge clk);
      end
      repeat (3) @(posedge clk);
    end
    $display("%0d programs halted, %0d mismatches, %0d protocol errors",
             haltCount, mismatchCount, protocolCount);
    if (mismatchCount == 0 && protocolCount == 0 && haltCount == NUM_PROGS) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the core did not finish all programs within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/cpuPkg.sv
design/alu.sv
design/registerFile.sv
design/programCounter.sv
design/instrDecoder.sv
design/microcodeRom.sv
design/controlFsm.sv
design/cpuCore.sv
dv/cpuChecker.sv
dv/cpuCoreTb.sv
